// File: rtl/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
	parameter int DEPTH = 64
) (
	input  logic                   clk,
	input  logic                   fsm_rst,
	input  logic                   flush,
	input  logic                   w_v,
	input  logic [7:0]             w_d,
	input  logic                   r_v,
	output logic [7:0]             r_q,
	output logic                   empty,
	output logic [$clog2(DEPTH):0] count
);

localparam int AW = $clog2(DEPTH);

logic [7:0] mem [DEPTH];

// One extra bit tells full from empty
logic [AW:0] wr_ptr;
logic [AW:0] rd_ptr;
logic        full;

assign count = wr_ptr - rd_ptr;
assign empty = (count == '0);
assign full  = count[AW];

always_ff @(posedge clk) begin
	if (fsm_rst || flush) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
	end
	else begin
		if (w_v && !full) wr_ptr <= wr_ptr + 1'b1;
		if (r_v && !empty) rd_ptr <= rd_ptr + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (w_v && !full) mem[wr_ptr[AW-1:0]] <= w_d;
	if (r_v) r_q <= mem[rd_ptr[AW-1:0]]; // Data follows one cycle after r_v
end

endmodule

// File: rtl/crc32.sv
`timescale 1ns/1ps

module crc32 (
	input  logic        clk,
	input  logic        fsm_rst,
	input  logic        init,
	input  logic [7:0]  d,
	input  logic        v,
	output logic [31:0] crc,
	output logic        ok
);

logic [31:0] rem;

// One byte through the reflected polynomial, low bit first
function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
	logic [31:0] r;
	r = c ^ {24'h0, b};
	for (int i = 0; i < 8; i++) begin
		r = r[0] ? ((r >> 1) ^ eth_pkg::CRC_POLY) : (r >> 1);
	end
	return r;
endfunction

always_ff @(posedge clk) begin
	if (fsm_rst || init) begin
		rem <= '1;
	end
	else if (v) begin
		rem <= crc_byte(rem, d);
	end
end

assign crc = ~rem; // Sent low byte first
assign ok  = (rem == eth_pkg::CRC_RESIDUE);

endmodule

// File: rtl/eth_mac.sv
`timescale 1ns/1ps

module eth_mac #(
	parameter int TX_FIFO_DEPTH = 64
) (
	input  logic               clk,
	input  logic               fsm_rst,
	input  eth_pkg::mac_addr_t dev_mac_addr,

	input  logic [7:0]         tx_d,
	input  logic               tx_v,
	input  eth_pkg::mac_hdr_t  tx_hdr,
	input  logic               tx_avl,
	output logic               tx_rdy,
	output logic               tx_busy,

	output logic [7:0]         phy_tx_d,
	output logic               phy_tx_v,
	input  logic [7:0]         phy_rx_d,
	input  logic               phy_rx_v,
	input  logic               phy_rx_e,

	output logic [7:0]         rx_d,
	output logic               rx_v,
	output logic               rx_sof,
	output logic               rx_eof,
	output logic               rx_err,
	output eth_pkg::mac_hdr_t  rx_hdr
);

localparam int LEN_W = $clog2(TX_FIFO_DEPTH) + 1;

logic             fifo_r_v;
logic [7:0]       fifo_r_q;
logic [LEN_W-1:0] fifo_count;
logic             fifo_flush;

mac_stream_if rx_if ();

//////////////////////////////////////////////////////////////////////
// Transmit path
//////////////////////////////////////////////////////////////////////

byte_fifo #(
	.DEPTH (TX_FIFO_DEPTH)
) tx_fifo (
	.clk     (clk),
	.fsm_rst (fsm_rst),
	.flush   (fifo_flush),
	.w_v     (tx_v),
	.w_d     (tx_d),
	.r_v     (fifo_r_v),
	.r_q     (fifo_r_q),
	.empty   (),
	.count   (fifo_count)
);

eth_tx #(
	.TX_FIFO_DEPTH (TX_FIFO_DEPTH)
) tx (
	.clk          (clk),
	.fsm_rst      (fsm_rst),
	.dev_mac_addr (dev_mac_addr),
	.tx_hdr       (tx_hdr),
	.avl          (tx_avl),
	.rdy          (tx_rdy),
	.busy         (tx_busy),
	.fifo_r_v     (fifo_r_v),
	.fifo_r_q     (fifo_r_q),
	.fifo_count   (fifo_count),
	.fifo_flush   (fifo_flush),
	.phy_d        (phy_tx_d),
	.phy_v        (phy_tx_v)
);

//////////////////////////////////////////////////////////////////////
// Receive path
//////////////////////////////////////////////////////////////////////

eth_rx rx (
	.clk          (clk),
	.fsm_rst      (fsm_rst),
	.dev_mac_addr (dev_mac_addr),
	.phy_d        (phy_rx_d),
	.phy_v        (phy_rx_v),
	.phy_e        (phy_rx_e),
	.mac          (rx_if)
);

assign rx_d   = rx_if.d;
assign rx_v   = rx_if.v;
assign rx_sof = rx_if.sof;
assign rx_eof = rx_if.eof;
assign rx_err = rx_if.err;
assign rx_hdr = rx_if.hdr;

endmodule

// File: rtl/eth_pkg.sv
package eth_pkg;

	//////////////////////////////////////////////////////////////////////
	// Header types
	//////////////////////////////////////////////////////////////////////

	// Byte 5 is the first one on the wire
	typedef logic [5:0][7:0] mac_addr_t;

	typedef logic [1:0][7:0] ethertype_t;

	typedef struct packed {
		mac_addr_t  dst_mac_addr;
		mac_addr_t  src_mac_addr;
		ethertype_t ethertype;
	} mac_hdr_t;

	localparam int HDR_LEN = 14; // Destination, source and ethertype

	//////////////////////////////////////////////////////////////////////
	// Frame constants
	//////////////////////////////////////////////////////////////////////

	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam int         PREAMBLE_LEN  = 7;
	localparam logic [7:0] SFD_BYTE      = 8'hd5;

	// Shorter payloads are padded with zero bytes
	localparam int MIN_PAYLOAD = 46;

	localparam int FCS_LEN = 4;

	// Reflected form of the IEEE 802.3 polynomial
	localparam logic [31:0] CRC_POLY = 32'hedb88320;

	// Remainder left in the register after a good frame and its FCS
	localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

	localparam mac_addr_t BROADCAST_ADDR = '1;

	localparam int IFG_LEN = 12; // Idle cycles after each transmitted frame

endpackage

// File: rtl/eth_rx.sv
`timescale 1ns/1ps

module eth_rx (
	input  logic               clk,
	input  logic               fsm_rst,
	input  eth_pkg::mac_addr_t dev_mac_addr,
	input  logic [7:0]         phy_d,
	input  logic               phy_v,
	input  logic               phy_e,
	mac_stream_if.src          mac
);

localparam int HDR_LEN = eth_pkg::HDR_LEN;

typedef enum logic [1:0] {
	sfd_s,
	hdr_s,
	pay_s
} rx_state_t;

rx_state_t state;

logic [3:0]                hdr_cnt;
logic [HDR_LEN-1:0][7:0]   hdr_sr;
eth_pkg::mac_hdr_t         hdr_nxt;
eth_pkg::mac_hdr_t         hdr_q;

logic accept;
logic sof_pend;
logic err_seen;
logic crc_ok;
logic emit;
logic frame_end;

// Four bytes of hold-back so the FCS never reaches the user
logic [3:0][7:0] dly_d;
logic [3:0]      dly_p;

assign hdr_nxt   = {hdr_sr[HDR_LEN-2:0], phy_d};
assign emit      = phy_v && (state == pay_s) && dly_p[3] && accept;
assign frame_end = !phy_v && (state == pay_s);

crc32 rx_crc (
	.clk     (clk),
	.fsm_rst (fsm_rst),
	.init    (state == sfd_s),
	.d       (phy_d),
	.v       (phy_v && (state != sfd_s)),
	.crc     (),
	.ok      (crc_ok)
);

//////////////////////////////////////////////////////////////////////
// Frame control
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (fsm_rst) begin
		state    <= sfd_s;
		hdr_cnt  <= '0;
		accept   <= 1'b0;
		sof_pend <= 1'b0;
		err_seen <= 1'b0;
		dly_p    <= '0;
		mac.v    <= 1'b0;
		mac.sof  <= 1'b0;
		mac.eof  <= 1'b0;
		mac.err  <= 1'b0;
	end
	else begin
		err_seen <= phy_v && (err_seen || phy_e); // Clears while the line is idle
		dly_p    <= {dly_p[2:0], phy_v && (state == pay_s)};

		mac.v   <= emit;
		mac.sof <= emit && sof_pend;
		mac.eof <= frame_end && accept;
		mac.err <= frame_end && accept && (!crc_ok || err_seen);
		if (emit) sof_pend <= 1'b0;

		case (state)
			sfd_s : begin
				if (phy_v && (phy_d == eth_pkg::SFD_BYTE)) begin
					hdr_cnt <= '0;
					state   <= hdr_s;
				end
			end
			hdr_s : begin
				if (!phy_v) state <= sfd_s; // Runt, nothing was forwarded yet
				else begin
					hdr_cnt <= hdr_cnt + 1'b1;
					if (hdr_cnt == 4'(HDR_LEN - 1)) begin
						accept <= (hdr_nxt.dst_mac_addr == dev_mac_addr) ||
							(hdr_nxt.dst_mac_addr == eth_pkg::BROADCAST_ADDR);
						sof_pend <= 1'b1;
						state    <= pay_s;
					end
				end
			end
			pay_s : begin
				if (!phy_v) state <= sfd_s;
			end
			default : state <= sfd_s;
		endcase
	end
end

//////////////////////////////////////////////////////////////////////
// Data path
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	dly_d <= {dly_d[2:0], phy_d};
	mac.d <= dly_d[3];
	if (phy_v && (state == hdr_s)) begin
		hdr_sr <= hdr_nxt;
		if (hdr_cnt == 4'(HDR_LEN - 1)) hdr_q <= hdr_nxt;
	end
	if (emit && sof_pend) mac.hdr <= hdr_q; // Held until the next accepted frame
end

endmodule

// File: rtl/eth_tx.sv
`timescale 1ns/1ps

module eth_tx #(
	parameter int TX_FIFO_DEPTH = 64
) (
	input  logic                           clk,
	input  logic                           fsm_rst,
	input  eth_pkg::mac_addr_t             dev_mac_addr,
	input  eth_pkg::mac_hdr_t              tx_hdr,
	input  logic                           avl,
	output logic                           rdy,
	output logic                           busy,
	output logic                           fifo_r_v,
	input  logic [7:0]                     fifo_r_q,
	input  logic [$clog2(TX_FIFO_DEPTH):0] fifo_count,
	output logic                           fifo_flush,
	output logic [7:0]                     phy_d,
	output logic                           phy_v
);

localparam int LEN_W   = $clog2(TX_FIFO_DEPTH) + 1;
localparam int CNT_W   = (LEN_W > 7) ? LEN_W : 7; // Must also reach the pad length
localparam int HDR_LEN = eth_pkg::HDR_LEN;

localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(eth_pkg::PREAMBLE_LEN);
localparam logic [CNT_W-1:0] HDR_TOP  = CNT_W'(HDR_LEN - 1);
localparam logic [CNT_W-1:0] PAD_LAST = CNT_W'(eth_pkg::MIN_PAYLOAD - 1);
localparam logic [CNT_W-1:0] MIN_LEN  = CNT_W'(eth_pkg::MIN_PAYLOAD);
localparam logic [CNT_W-1:0] FCS_LAST = CNT_W'(eth_pkg::FCS_LEN - 1);
localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(eth_pkg::IFG_LEN + 1);

typedef enum logic [3:0] {
	idle_s,
	pre_s,
	dst_s,
	src_s,
	type_s,
	pay_s,
	pad_s,
	fcs_s,
	gap_s
} tx_state_t;

typedef enum logic [1:0] {
	sel_byte,
	sel_fifo,
	sel_fcs
} sel_t;

tx_state_t state;

logic [CNT_W-1:0]        cnt;
logic [CNT_W-1:0]        len;
logic [HDR_LEN-1:0][7:0] hdr_q;

// First output stage, one cycle behind the FSM to match the FIFO read latency
logic       a_v;
logic       a_crc;
sel_t       a_sel;
logic [7:0] a_byte;
logic [1:0] a_idx;

logic [7:0]  tx_byte;
logic [31:0] fcs;

assign fifo_r_v   = (state == pay_s);
assign fifo_flush = (state == gap_s) && (cnt == '0);

crc32 tx_crc (
	.clk     (clk),
	.fsm_rst (fsm_rst),
	.init    (state == pre_s),
	.d       (tx_byte),
	.v       (a_crc),
	.crc     (fcs),
	.ok      ()
);

//////////////////////////////////////////////////////////////////////
// Frame sequencer
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (fsm_rst) begin
		state <= idle_s;
		cnt   <= '0;
		rdy   <= 1'b0;
		busy  <= 1'b0;
	end
	else begin
		rdy <= 1'b0;
		case (state)
			idle_s : begin
				if (avl) begin
					rdy   <= 1'b1;
					busy  <= 1'b1;
					hdr_q <= {tx_hdr.dst_mac_addr, dev_mac_addr, tx_hdr.ethertype};
					len   <= CNT_W'(fifo_count);
					cnt   <= '0;
					state <= pre_s;
				end
			end
			pre_s : begin
				cnt <= (cnt == PRE_LAST) ? '0 : cnt + 1'b1;
				if (cnt == PRE_LAST) state <= dst_s;
			end
			dst_s : begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(5)) state <= src_s;
			end
			src_s : begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(11)) state <= type_s;
			end
			type_s : begin
				cnt <= (cnt == HDR_TOP) ? '0 : cnt + 1'b1;
				if (cnt == HDR_TOP) state <= (len == '0) ? pad_s : pay_s;
			end
			pay_s : begin
				if (cnt == len - 1'b1) begin
					cnt   <= (len < MIN_LEN) ? cnt + 1'b1 : '0;
					state <= (len < MIN_LEN) ? pad_s : fcs_s;
				end
				else cnt <= cnt + 1'b1;
			end
			pad_s : begin
				cnt <= (cnt == PAD_LAST) ? '0 : cnt + 1'b1;
				if (cnt == PAD_LAST) state <= fcs_s;
			end
			fcs_s : begin
				cnt <= (cnt == FCS_LAST) ? '0 : cnt + 1'b1;
				if (cnt == FCS_LAST) state <= gap_s;
			end
			gap_s : begin
				cnt <= cnt + 1'b1;
				if (cnt == GAP_LAST) begin
					busy  <= 1'b0; // Counts the two output stages still draining
					state <= idle_s;
				end
			end
			default : state <= idle_s;
		endcase
	end
end

//////////////////////////////////////////////////////////////////////
// Output stages
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (fsm_rst) begin
		a_v   <= 1'b0;
		a_crc <= 1'b0;
		phy_v <= 1'b0;
	end
	else begin
		a_v   <= (state != idle_s) && (state != gap_s);
		a_crc <= (state inside {dst_s, src_s, type_s, pay_s, pad_s});
		phy_v <= a_v;
	end
end

always_ff @(posedge clk) begin
	a_idx <= cnt[1:0];
	a_sel <= (state == pay_s) ? sel_fifo : (state == fcs_s) ? sel_fcs : sel_byte;
	case (state)
		pre_s : a_byte <= (cnt == PRE_LAST) ? eth_pkg::SFD_BYTE : eth_pkg::PREAMBLE_BYTE;
		dst_s, src_s, type_s : a_byte <= hdr_q[HDR_TOP - cnt];
		default : a_byte <= 8'h00; // Pad bytes
	endcase
	phy_d <= tx_byte;
end

always_comb begin
	case (a_sel)
		sel_fifo : tx_byte = fifo_r_q;
		sel_fcs  : tx_byte = fcs[8*a_idx +: 8];
		default  : tx_byte = a_byte;
	endcase
end

endmodule

// File: rtl/mac_stream_if.sv
`timescale 1ns/1ps

// Receive user stream, one byte per cycle with frame markers
interface mac_stream_if;
	logic [7:0]        d;
	logic              v;
	logic              sof;
	logic              eof;
	logic              err; // Valid only with eof
	eth_pkg::mac_hdr_t hdr;

	modport src (output d, v, sof, eof, err, hdr);
	modport snk (input d, v, sof, eof, err, hdr);
endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module eth_mac_tb -o eth_mac_sim \
	&& ./obj_dir/eth_mac_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Simulation build or run failed"; exit 1; }
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim.f
rtl/eth_pkg.sv
rtl/mac_stream_if.sv
rtl/crc32.sv
rtl/byte_fifo.sv
rtl/eth_rx.sv
rtl/eth_tx.sv
rtl/eth_mac.sv
tests/eth_mac_sva.sv
tests/eth_mac_tb.sv

// File: tests/eth_mac_sva.sv
`timescale 1ns/1ps

module eth_mac_sva (
	input logic clk,
	input logic fsm_rst,
	input logic tx_v,
	input logic tx_busy,
	input logic phy_tx_v,
	input logic rx_v,
	input logic rx_sof
);

// Shortest legal frame on the line, preamble through FCS
localparam int MIN_FRAME = eth_pkg::PREAMBLE_LEN + 1 + eth_pkg::HDR_LEN +
	eth_pkg::MIN_PAYLOAD + eth_pkg::FCS_LEN;

logic [7:0] run_len; // Cycles phy_tx_v has stayed high without a break

always_ff @(posedge clk) begin
	if (fsm_rst) begin
		run_len <= '0;
	end
	else if (!phy_tx_v) begin
		run_len <= '0;
	end
	else if (run_len != '1) begin
		run_len <= run_len + 1'b1;
	end
end

no_write_busy: assert property (@(posedge clk) disable iff (fsm_rst) tx_v |-> !tx_busy)
	else $error("tx_v written while tx_busy is high");

tx_frame_whole: assert property (@(posedge clk) disable iff (fsm_rst)
	(!phy_tx_v && (run_len != '0)) |-> (run_len >= 8'(MIN_FRAME)))
	else $error("phy_tx_v dropped before the end of the FCS");

sof_with_v: assert property (@(posedge clk) disable iff (fsm_rst) rx_sof |-> rx_v)
	else $error("rx_sof raised without rx_v");

endmodule

// File: tests/eth_mac_tb.sv
`timescale 1ns/1ps

module eth_mac_tb;

localparam int TX_FIFO_DEPTH = 64;
localparam int TIMEOUT       = 400;
localparam int NUM_FRAMES    = 30;
localparam int NUM_INJECT    = 8;
localparam int PAY_OFS       = eth_pkg::PREAMBLE_LEN + 1 + eth_pkg::HDR_LEN;

logic               clk = 1'b0;
logic               fsm_rst;
eth_pkg::mac_addr_t dev_mac_addr;
logic [7:0]         tx_d;
logic               tx_v;
eth_pkg::mac_hdr_t  tx_hdr;
logic               tx_avl;
logic               tx_rdy;
logic               tx_busy;
logic [7:0]         phy_tx_d;
logic               phy_tx_v;
logic [7:0]         phy_rx_d;
logic               phy_rx_v;
logic               phy_rx_e;
logic [7:0]         rx_d;
logic               rx_v;
logic               rx_sof;
logic               rx_eof;
logic               rx_err;
eth_pkg::mac_hdr_t  rx_hdr;

// Injection side of the receive mux
logic       inj_sel;
logic [7:0] inj_d;
logic       inj_v;
logic       inj_e;

// What the receive monitor saw since the last clear
logic [7:0]        rx_q [$];
int                sof_cnt;
int                sof_pos;
int                eof_cnt;
logic [1:0]        eof_status;
eth_pkg::mac_hdr_t hdr_got;
int                rdy_cnt;

logic [7:0] wire_q [$]; // Expected line bytes of the current frame
logic [7:0] pay_q [$];  // Padded payload of the current frame

always #2 clk = ~clk;

assign phy_rx_d = inj_sel ? inj_d : phy_tx_d;
assign phy_rx_v = inj_sel ? inj_v : phy_tx_v;
assign phy_rx_e = inj_sel ? inj_e : 1'b0;

eth_mac #(
	.TX_FIFO_DEPTH (TX_FIFO_DEPTH)
) dut0 (.*);

bind eth_mac eth_mac_sva sva0 (
	.clk      (clk),
	.fsm_rst  (fsm_rst),
	.tx_v     (tx_v),
	.tx_busy  (tx_busy),
	.phy_tx_v (phy_tx_v),
	.rx_v     (rx_v),
	.rx_sof   (rx_sof)
);

always @(posedge clk) begin
	if (rx_sof) begin
		sof_cnt++;
		sof_pos = rx_q.size();
		hdr_got = rx_hdr;
	end
	if (rx_v) rx_q.push_back(rx_d);
	if (rx_eof) begin
		eof_status = {rx_eof, rx_err};
		eof_cnt++;
	end
	if (tx_rdy) rdy_cnt++;
end

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Bit-serial CRC-32, one feedback bit per input bit
function automatic logic [31:0] crc_update(logic [31:0] c, logic [7:0] b);
	logic fb;
	for (int i = 0; i < 8; i++) begin
		fb = c[0] ^ b[i];
		c  = {1'b0, c[31:1]} ^ (fb ? eth_pkg::CRC_POLY : 32'h0);
	end
	return c;
endfunction

function automatic eth_pkg::mac_addr_t random_addr();
	eth_pkg::mac_addr_t a;
	a = 48'({$urandom, $urandom});
	a[5][0] = 1'b0; // Unicast, so never broadcast
	return a;
endfunction

task automatic build_frame(input eth_pkg::mac_hdr_t hdr, input int len);
	logic [eth_pkg::HDR_LEN-1:0][7:0] hb;
	logic [31:0]                      c;
	int                               plen;
	hb   = hdr;
	c    = '1;
	plen = (len < eth_pkg::MIN_PAYLOAD) ? eth_pkg::MIN_PAYLOAD : len;
	pay_q.delete();
	for (int i = 0; i < plen; i++) pay_q.push_back((i < len) ? 8'($urandom) : 8'h00);
	wire_q.delete();
	for (int i = 0; i < eth_pkg::PREAMBLE_LEN; i++) wire_q.push_back(eth_pkg::PREAMBLE_BYTE);
	wire_q.push_back(eth_pkg::SFD_BYTE);
	for (int i = 0; i < eth_pkg::HDR_LEN; i++) wire_q.push_back(hb[eth_pkg::HDR_LEN-1-i]);
	for (int i = 0; i < plen; i++) wire_q.push_back(pay_q[i]);
	for (int i = PAY_OFS - eth_pkg::HDR_LEN; i < wire_q.size(); i++) begin
		c = crc_update(c, wire_q[i]);
	end
	c = ~c;
	for (int i = 0; i < eth_pkg::FCS_LEN; i++) wire_q.push_back(c[8*i +: 8]); // Low byte first
endtask

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

task automatic stop_on_error(input string why);
	$display("%s", why);
	$display("Test failures found");
	$fatal(1, "stopped at the first error");
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string name);
	if (got !== exp)
		stop_on_error($sformatf("mismatch at %0t: %s got %02h expected %02h",
			$time, name, got, exp));
endtask

task automatic check_hdr(input eth_pkg::mac_hdr_t got, input eth_pkg::mac_hdr_t exp,
		input string name);
	if (got !== exp)
		stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
			$time, name, got, exp));
endtask

task automatic check_status(input logic [1:0] got, input logic [1:0] exp, input string name);
	if (got !== exp)
		stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
			$time, name, got, exp));
endtask

task automatic check_bit(input logic got, input logic exp, input string name);
	if (got !== exp)
		stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
			$time, name, got, exp));
endtask

task automatic check_count(input int got, input int exp, input string name);
	if (got != exp)
		stop_on_error($sformatf("mismatch at %0t: %s got %0d expected %0d",
			$time, name, got, exp));
endtask

task automatic clear_rx_record();
	rx_q.delete();
	sof_cnt    = 0;
	sof_pos    = -1;
	eof_cnt    = 0;
	eof_status = '0;
	rdy_cnt    = 0;
endtask

//////////////////////////////////////////////////////////////////////
// Frame sequences
//////////////////////////////////////////////////////////////////////

task automatic send_frame(input eth_pkg::mac_addr_t dst, input int len, input bit expect_rx);
	eth_pkg::mac_hdr_t hdr;
	eth_pkg::mac_hdr_t exp_hdr;
	int                n;
	int                gap;
	hdr.dst_mac_addr     = dst;
	hdr.src_mac_addr     = random_addr(); // Replaced by the device address
	hdr.ethertype        = 16'($urandom);
	exp_hdr              = hdr;
	exp_hdr.src_mac_addr = dev_mac_addr;
	build_frame(exp_hdr, len);
	clear_rx_record();
	inj_sel = 1'b0;
	for (int i = 0; i < len; i++) begin
		@(posedge clk);
		#1;
		tx_v = 1'b1;
		tx_d = pay_q[i];
	end
	@(posedge clk);
	#1;
	tx_v   = 1'b0;
	tx_hdr = hdr;
	tx_avl = 1'b1;
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while (!tx_rdy && n < TIMEOUT);
	if (!tx_rdy) stop_on_error("timeout waiting for tx_rdy");
	check_bit(tx_busy, 1'b1, "tx_busy");
	#1 tx_avl = 1'b0;
	n = 0;
	while (!phy_tx_v && n < TIMEOUT) begin
		@(posedge clk);
		n++;
	end
	if (!phy_tx_v) stop_on_error("timeout waiting for the frame on phy_tx_v");
	for (int i = 0; i < wire_q.size(); i++) begin
		if (i > 0) @(posedge clk);
		check_bit(phy_tx_v, 1'b1, "phy_tx_v");
		check_bit(tx_busy, 1'b1, "tx_busy");
		check_byte(phy_tx_d, wire_q[i], "phy_tx_d");
	end
	@(posedge clk);
	check_bit(phy_tx_v, 1'b0, "phy_tx_v");
	gap = 0;
	while (tx_busy && gap < TIMEOUT) begin
		gap++;
		@(posedge clk);
	end
	check_count(gap, eth_pkg::IFG_LEN, "tx_busy cycles after the FCS");
	check_count(rdy_cnt, 1, "tx_rdy pulses");
	if (expect_rx) begin
		check_count(sof_cnt, 1, "rx_sof pulses");
		check_count(eof_cnt, 1, "rx_eof pulses");
		check_count(sof_pos, 0, "rx_sof byte position");
		check_count(rx_q.size(), pay_q.size(), "rx_v bytes");
		for (int i = 0; i < pay_q.size(); i++) check_byte(rx_q[i], pay_q[i], "rx_d");
		check_hdr(hdr_got, exp_hdr, "rx_hdr");
		check_status(eof_status, 2'b10, "rx_eof and rx_err");
	end
	else begin
		check_count(rx_q.size(), 0, "rx_v bytes of a filtered frame");
		check_count(sof_cnt, 0, "rx_sof pulses of a filtered frame");
		check_count(eof_cnt, 0, "rx_eof pulses of a filtered frame");
	end
endtask

// Drives a damaged frame straight into the receiver
task automatic inject_frame(input int len, input bit line_err);
	eth_pkg::mac_hdr_t hdr;
	int                pos;
	int                n;
	hdr.dst_mac_addr = dev_mac_addr;
	hdr.src_mac_addr = random_addr();
	hdr.ethertype    = 16'($urandom);
	build_frame(hdr, len);
	if (line_err) pos = int'($urandom_range(wire_q.size() - 1, 0));
	else begin
		pos = PAY_OFS + int'($urandom_range(pay_q.size() - 1, 0));
		wire_q[pos] = wire_q[pos] ^ (8'h01 << $urandom_range(7, 0));
	end
	clear_rx_record();
	inj_sel = 1'b1;
	for (int i = 0; i < wire_q.size(); i++) begin
		@(posedge clk);
		#1;
		inj_v = 1'b1;
		inj_d = wire_q[i];
		inj_e = line_err && (i == pos);
	end
	@(posedge clk);
	#1;
	inj_v = 1'b0;
	inj_e = 1'b0;
	n = 0;
	while (eof_cnt == 0 && n < TIMEOUT) begin
		@(posedge clk);
		#1;
		n++;
	end
	if (eof_cnt == 0) stop_on_error("timeout waiting for rx_eof after an injected frame");
	check_status(eof_status, 2'b11, "rx_eof and rx_err");
	inj_sel = 1'b0;
endtask

initial begin
	int                 len;
	eth_pkg::mac_addr_t other;
	void'($urandom(24755));
	fsm_rst      = 1'b1;
	tx_d         = '0;
	tx_v         = 1'b0;
	tx_hdr       = '0;
	tx_avl       = 1'b0;
	inj_sel      = 1'b0;
	inj_d        = '0;
	inj_v        = 1'b0;
	inj_e        = 1'b0;
	dev_mac_addr = random_addr();
	clear_rx_record();
	repeat (16) @(posedge clk);
	check_bit(phy_tx_v, 1'b0, "phy_tx_v in reset");
	check_bit(tx_rdy, 1'b0, "tx_rdy in reset");
	check_bit(tx_busy, 1'b0, "tx_busy in reset");
	check_bit(rx_v, 1'b0, "rx_v in reset");
	check_bit(rx_sof, 1'b0, "rx_sof in reset");
	check_bit(rx_eof, 1'b0, "rx_eof in reset");
	#1 fsm_rst = 1'b0;

	// Own address, broadcast and a foreign address in turn
	for (int i = 0; i < NUM_FRAMES; i++) begin
		len = (i == 0) ? 1 : (i == 1) ? eth_pkg::MIN_PAYLOAD : (i == 3) ? TX_FIFO_DEPTH
			: int'($urandom_range(TX_FIFO_DEPTH, 1));
		if (i % 3 == 0) send_frame(dev_mac_addr, len, 1'b1);
		else if (i % 3 == 1) send_frame(eth_pkg::BROADCAST_ADDR, len, 1'b1);
		else begin
			other = random_addr();
			if (other == dev_mac_addr) other[0] = ~other[0];
			send_frame(other, len, 1'b0);
		end
	end

	for (int j = 0; j < NUM_INJECT; j++) begin
		inject_frame(int'($urandom_range(TX_FIFO_DEPTH, 1)), (j % 2) == 1);
	end
	send_frame(dev_mac_addr, int'($urandom_range(TX_FIFO_DEPTH, 1)), 1'b1); // Clean after errors

	$display("All tests passed!");
	$finish;
end

endmodule
